// ==== list.f ====
hdl/ifu_pkg.sv
hdl/mem_req_if.sv
hdl/page_walker.sv
hdl/line_refill.sv
hdl/fetch_ctrl.sv
hdl/ifu_top.sv
tests/tb_mem_model.sv
tests/tb_ifu.sv

// ==== Makefile ====
SIM = verilator
FLAGS = --binary --timing --assert -j 0
TOP = tb_ifu
FILELIST = list.f
BUILD = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD)/V$(TOP)

lint:
	$(SIM) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)

// ==== tests/tb_ifu.sv ====
`timescale 1ns/10ps

module tb_ifu;
	import ifu_pkg::*;

	localparam int half_period = 4;
	localparam int n_requests = 9;
	localparam int cycles_per_req = 200;
	localparam logic [19:0] itlb_frame = 20'h00040;

	logic clk;
	logic rst;
	logic fetch_ena_i;
	word_t fetch_addr_i;
	word_t cat_base_i;
	logic itlb_valid_i;
	logic itlb_hit_i;
	word_t itlb_paddr_i;
	logic icache_valid_i;
	logic icache_hit_i;
	word_t icache_data_i;
	logic mem_valid_i;
	word_t mem_data_i;
	logic fetch_valid_o;
	logic fetch_except_o;
	word_t fetch_data_o;
	logic itlb_ena_o;
	word_t itlb_vaddr_o;
	logic itlb_fill_valid_o;
	logic itlb_fill_ok_o;
	word_t itlb_fill_paddr_o;
	logic icache_ena_o;
	word_t icache_addr_o;
	logic icache_fill_valid_o;
	word_t icache_fill_addr_o;
	line_t icache_fill_line_o;
	logic mem_valid_o;
	word_t mem_addr_o;

	// expectations of the request in flight
	logic pending;
	logic acc;
	logic exp_hit;
	logic exp_unc;
	logic exp_walk;
	logic exp_refill;
	logic exp_ok;
	logic exp_except;
	word_t exp_data;
	word_t exp_paddr;
	word_t exp_line_addr;
	line_t exp_line;
	word_t exp_reads[$];
	logic itlb_on;
	word_t cached_lines[0:15];
	int n_cached;

	ifu_top UUT (.*);

	tb_mem_model u_mem (
		.clk(clk),
		.rst(rst),
		.req_valid_i(mem_valid_o),
		.req_addr_i(mem_addr_o),
		.rsp_valid_o(mem_valid_i),
		.rsp_data_o(mem_data_i)
	);

	always #(half_period) clk = ~clk;

	function automatic word_t mem_word(word_t a);
		return a ^ 32'hA5A5_0000;
	endfunction

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	// itlb holds page 0 only while itlb_on is set
	assign itlb_valid_i = itlb_ena_o;
	assign itlb_hit_i = itlb_ena_o && itlb_on && (itlb_vaddr_o[31:12] == 20'h0);
	assign itlb_paddr_i = {itlb_frame, itlb_vaddr_o[11:0]};

	assign icache_valid_i = icache_ena_o;
	assign icache_data_i = mem_word(icache_addr_o);

	always_comb begin
		icache_hit_i = 1'b0;
		for (int i = 0; i < 16; i++) begin
			if (i < n_cached && cached_lines[i] == {icache_addr_o[31:4], 4'h0}) begin
				icache_hit_i = icache_ena_o;
			end
		end
	end

	always @(posedge clk) begin
		if (icache_fill_valid_o && n_cached < 16) begin
			cached_lines[n_cached] <= icache_fill_addr_o;
			n_cached <= n_cached + 1;
		end
	end

	// every memory read must match the next expected address
	always @(posedge clk) begin
		if (rst && mem_valid_o && mem_valid_i) begin
			assert (exp_reads.size() != 0 && mem_addr_o == exp_reads[0])
				void'(exp_reads.pop_front());
			else
				stop_on_error($sformatf("ERR mem_addr_o got %h exp %h", mem_addr_o,
					exp_reads.size() != 0 ? exp_reads[0] : 32'hffff_ffff));
		end
	end

	assert property (@(posedge clk) disable iff (!rst) !pending |-> !(fetch_valid_o
			|| fetch_except_o || mem_valid_o || itlb_ena_o || icache_ena_o
			|| itlb_fill_valid_o || icache_fill_valid_o))
		else stop_on_error("strobe or enable active with no request outstanding");
	assert property (@(posedge clk) disable iff (!rst) acc && exp_hit |=> fetch_valid_o)
		else stop_on_error("hit fetch did not complete one cycle after acceptance");
	assert property (@(posedge clk) disable iff (!rst) pending && exp_hit |-> !mem_valid_o)
		else stop_on_error("memory request made on a cache hit");
	assert property (@(posedge clk) disable iff (!rst)
			pending && exp_unc |-> !itlb_ena_o && !icache_ena_o)
		else stop_on_error("lookup enabled during an uncached fetch");
	assert property (@(posedge clk) disable iff (!rst)
			fetch_valid_o |-> fetch_data_o == exp_data)
		else stop_on_error($sformatf("ERR fetch_data_o got %h exp %h",
			$sampled(fetch_data_o), $sampled(exp_data)));
	assert property (@(posedge clk) disable iff (!rst)
			fetch_valid_o |-> fetch_except_o == exp_except)
		else stop_on_error($sformatf("ERR fetch_except_o got %h exp %h",
			$sampled(fetch_except_o), $sampled(exp_except)));
	assert property (@(posedge clk) disable iff (!rst)
			itlb_fill_valid_o |-> exp_walk && itlb_fill_ok_o == exp_ok)
		else stop_on_error($sformatf("ERR itlb_fill_ok_o got %h exp %h",
			$sampled(itlb_fill_ok_o), $sampled(exp_ok)));
	assert property (@(posedge clk) disable iff (!rst)
			itlb_fill_valid_o && exp_ok |-> itlb_fill_paddr_o == exp_paddr)
		else stop_on_error($sformatf("ERR itlb_fill_paddr_o got %h exp %h",
			$sampled(itlb_fill_paddr_o), $sampled(exp_paddr)));
	assert property (@(posedge clk) disable iff (!rst)
			icache_fill_valid_o |-> exp_refill && icache_fill_addr_o == exp_line_addr)
		else stop_on_error($sformatf("ERR icache_fill_addr_o got %h exp %h",
			$sampled(icache_fill_addr_o), $sampled(exp_line_addr)));
	assert property (@(posedge clk) disable iff (!rst)
			icache_fill_valid_o |-> icache_fill_line_o == exp_line)
		else stop_on_error($sformatf("ERR icache_fill_line_o got %h exp %h",
			$sampled(icache_fill_line_o), $sampled(exp_line)));

	task automatic expect_read(input word_t addr);
		exp_reads.push_back(addr);
	endtask

	task automatic expect_refill(input word_t paddr);
		word_t base;
		base = {paddr[31:4], 4'h0};
		for (int k = 0; k < 4; k++) begin
			exp_reads.push_back(base + word_t'(k * 4));
			exp_line[32*k +: 32] = mem_word(base + word_t'(k * 4));
		end
		exp_line_addr = base;
		exp_refill = 1'b1;
	endtask

	// level 1 index vaddr[31:22], level 2 index vaddr[21:12]
	task automatic expect_walk(input word_t vaddr, input word_t cat, input logic [19:0] frame1,
			input logic second, input logic ok, input word_t paddr);
		exp_reads.push_back({cat[31:12], vaddr[31:22], 2'b00});
		if (second) begin
			exp_reads.push_back({frame1, vaddr[21:12], 2'b00});
		end
		exp_walk = 1'b1;
		exp_ok = ok;
		exp_paddr = paddr;
	endtask

	task automatic run_fetch(input word_t addr, input word_t data, input logic except,
			input logic hit, input logic unc);
		logic filled;
		filled = 1'b0;
		exp_data = data;
		exp_except = except;
		exp_hit = hit;
		exp_unc = unc;
		@(posedge clk);
		fetch_ena_i <= 1'b1;
		fetch_addr_i <= addr;
		pending <= 1'b1;
		acc <= 1'b1;
		@(posedge clk);
		acc <= 1'b0;
		while (!fetch_valid_o) begin
			@(posedge clk);
			if (itlb_fill_valid_o) begin
				filled = 1'b1;
			end
		end
		fetch_ena_i <= 1'b0;
		pending <= 1'b0;
		assert (exp_reads.size() == 0)
		else stop_on_error("expected memory reads missing at end of fetch");
		assert (filled == exp_walk)
		else stop_on_error("itlb fill missing at the end of a walk");
		exp_walk = 1'b0;
		exp_refill = 1'b0;
	endtask

	initial begin
		#(2 * half_period * (cycles_per_req * n_requests + 100));
		stop_on_error("timeout waiting for fetch_valid_o");
	end

	initial begin
		void'($urandom(32'hde25));
		clk = 1'b0;
		rst = 1'b0;
		fetch_ena_i = 1'b0;
		fetch_addr_i = '0;
		cat_base_i = '0;
		pending = 1'b0;
		acc = 1'b0;
		exp_hit = 1'b0;
		exp_unc = 1'b0;
		exp_walk = 1'b0;
		exp_refill = 1'b0;
		exp_ok = 1'b0;
		exp_except = 1'b0;
		exp_data = '0;
		exp_paddr = '0;
		exp_line_addr = '0;
		exp_line = '0;
		itlb_on = 1'b0;
		n_cached = 0;
		repeat (16) @(posedge clk);
		rst <= 1'b1;
		repeat (20) @(posedge clk);

		expect_read(32'h0000_1234);
		run_fetch(32'h0000_1234, mem_word(32'h0000_1234), 1'b0, 1'b0, 1'b1);
		// unmapped miss then hit in the same line
		expect_refill(32'h0000_0008);
		run_fetch(32'h0000_0008, mem_word(32'h0000_0008), 1'b0, 1'b0, 1'b0);
		run_fetch(32'h0000_000c, mem_word(32'h0000_000c), 1'b0, 1'b1, 1'b0);

		itlb_on <= 1'b1;
		expect_refill({itlb_frame, 12'h000});
		run_fetch(32'h0000_0000, mem_word({itlb_frame, 12'h000}), 1'b0, 1'b0, 1'b0);
		run_fetch(32'h0000_0004, mem_word({itlb_frame, 12'h004}), 1'b0, 1'b1, 1'b0);

		// itlb misses from here on
		itlb_on <= 1'b0;
		cat_base_i <= 32'h0010_0000;
		expect_walk(32'h4, 32'h0010_0000, 20'h00200, 1'b1, 1'b1, 32'h0003_0004);
		expect_refill(32'h0003_0004);
		run_fetch(32'h0000_0004, mem_word(32'h0003_0004), 1'b0, 1'b0, 1'b0);
		expect_walk(32'h0, 32'h0010_0000, 20'h00200, 1'b1, 1'b1, 32'h0003_0000);
		run_fetch(32'h0000_0000, mem_word(32'h0003_0000), 1'b0, 1'b0, 1'b0);

		cat_base_i <= 32'h0011_0000;
		expect_walk(32'h0, 32'h0011_0000, 20'h00000, 1'b0, 1'b0, 32'h0);
		run_fetch(32'h0000_0000, 32'h0, 1'b1, 1'b0, 1'b0);
		cat_base_i <= 32'h0012_0000;
		expect_walk(32'h0, 32'h0012_0000, 20'h00210, 1'b1, 1'b0, 32'h0);
		run_fetch(32'h0000_0000, 32'h0, 1'b1, 1'b0, 1'b0);

		repeat (5) @(posedge clk);
		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== tests/tb_mem_model.sv ====
`timescale 1ns/10ps

module tb_mem_model (
	input logic clk,
	input logic rst,
	input logic req_valid_i,
	input ifu_pkg::word_t req_addr_i,
	output logic rsp_valid_o,
	output ifu_pkg::word_t rsp_data_o
);
	import ifu_pkg::*;

	logic [2:0] delay;

	// page tables live in a few fixed pages, plain data everywhere else
	function automatic word_t read_word(word_t a);
		case (a[31:12])
			20'h00100: return {1'b1, 20'h00200, 11'h000};
			20'h00110: return 32'h0000_0000;
			20'h00120: return {1'b1, 20'h00210, 11'h000};
			20'h00200: return {1'b1, 20'h00030, 11'h000};
			20'h00210: return 32'h0000_0000;
			default: return a ^ 32'hA5A5_0000;
		endcase
	endfunction

	initial begin
		rsp_valid_o = 1'b0;
		rsp_data_o = '0;
	end

	always @(posedge clk) begin
		if (!rst) begin
			rsp_valid_o <= 1'b0;
			rsp_data_o <= '0;
			delay <= 3'($urandom_range(4, 0));
		end else begin
			rsp_valid_o <= 1'b0;
			// no count in the response cycle since the request may change there
			if (req_valid_i && !rsp_valid_o) begin
				if (delay == 3'd0) begin
					rsp_valid_o <= 1'b1;
					rsp_data_o <= read_word(req_addr_i);
					delay <= 3'($urandom_range(4, 0));
				end else begin
					delay <= delay - 3'd1;
				end
			end
		end
	end

endmodule

// ==== hdl/ifu_top.sv ====
`timescale 1ns/10ps

module ifu_top (
	input logic clk,
	input logic rst,
	input logic fetch_ena_i,
	input ifu_pkg::word_t fetch_addr_i,
	input ifu_pkg::word_t cat_base_i,
	input logic itlb_valid_i,
	input logic itlb_hit_i,
	input ifu_pkg::word_t itlb_paddr_i,
	input logic icache_valid_i,
	input logic icache_hit_i,
	input ifu_pkg::word_t icache_data_i,
	input logic mem_valid_i,
	input ifu_pkg::word_t mem_data_i,
	output logic fetch_valid_o,
	output logic fetch_except_o,
	output ifu_pkg::word_t fetch_data_o,
	output logic itlb_ena_o,
	output ifu_pkg::word_t itlb_vaddr_o,
	output logic itlb_fill_valid_o,
	output logic itlb_fill_ok_o,
	output ifu_pkg::word_t itlb_fill_paddr_o,
	output logic icache_ena_o,
	output ifu_pkg::word_t icache_addr_o,
	output logic icache_fill_valid_o,
	output ifu_pkg::word_t icache_fill_addr_o,
	output ifu_pkg::line_t icache_fill_line_o,
	output logic mem_valid_o,
	output ifu_pkg::word_t mem_addr_o
);
	import ifu_pkg::*;

	logic walk_start;
	word_t walk_vaddr;
	logic walk_done;
	logic walk_fault;
	word_t walk_paddr;
	logic refill_start;
	word_t refill_paddr;
	logic refill_done;
	line_t refill_line;

	// one read channel per memory requester
	mem_req_if walk_mem ();
	mem_req_if refill_mem ();

	fetch_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.fetch_ena_i(fetch_ena_i),
		.fetch_addr_i(fetch_addr_i),
		.itlb_valid_i(itlb_valid_i),
		.itlb_hit_i(itlb_hit_i),
		.itlb_paddr_i(itlb_paddr_i),
		.icache_valid_i(icache_valid_i),
		.icache_hit_i(icache_hit_i),
		.icache_data_i(icache_data_i),
		.mem_valid_i(mem_valid_i),
		.mem_data_i(mem_data_i),
		.walk_done_i(walk_done),
		.walk_fault_i(walk_fault),
		.walk_paddr_i(walk_paddr),
		.refill_done_i(refill_done),
		.refill_line_i(refill_line),
		.fetch_valid_o(fetch_valid_o),
		.fetch_except_o(fetch_except_o),
		.fetch_data_o(fetch_data_o),
		.itlb_ena_o(itlb_ena_o),
		.itlb_vaddr_o(itlb_vaddr_o),
		.itlb_fill_valid_o(itlb_fill_valid_o),
		.itlb_fill_ok_o(itlb_fill_ok_o),
		.itlb_fill_paddr_o(itlb_fill_paddr_o),
		.icache_ena_o(icache_ena_o),
		.icache_addr_o(icache_addr_o),
		.icache_fill_valid_o(icache_fill_valid_o),
		.icache_fill_addr_o(icache_fill_addr_o),
		.icache_fill_line_o(icache_fill_line_o),
		.mem_valid_o(mem_valid_o),
		.mem_addr_o(mem_addr_o),
		.walk_start_o(walk_start),
		.walk_vaddr_o(walk_vaddr),
		.refill_start_o(refill_start),
		.refill_paddr_o(refill_paddr),
		.walk_mem(walk_mem.arbiter),
		.refill_mem(refill_mem.arbiter)
	);

	page_walker u_walker (
		.clk(clk),
		.rst(rst),
		.start_i(walk_start),
		.vaddr_i(walk_vaddr),
		.cat_base_i(cat_base_i),
		.done_o(walk_done),
		.fault_o(walk_fault),
		.paddr_o(walk_paddr),
		.mem(walk_mem.requester)
	);

	line_refill u_refill (
		.clk(clk),
		.rst(rst),
		.start_i(refill_start),
		.paddr_i(refill_paddr),
		.done_o(refill_done),
		.line_o(refill_line),
		.mem(refill_mem.requester)
	);

endmodule

// ==== hdl/fetch_ctrl.sv ====
`timescale 1ns/10ps

module fetch_ctrl (
	input logic clk,
	input logic rst,
	input logic fetch_ena_i,
	input ifu_pkg::word_t fetch_addr_i,
	input logic itlb_valid_i,
	input logic itlb_hit_i,
	input ifu_pkg::word_t itlb_paddr_i,
	input logic icache_valid_i,
	input logic icache_hit_i,
	input ifu_pkg::word_t icache_data_i,
	input logic mem_valid_i,
	input ifu_pkg::word_t mem_data_i,
	input logic walk_done_i,
	input logic walk_fault_i,
	input ifu_pkg::word_t walk_paddr_i,
	input logic refill_done_i,
	input ifu_pkg::line_t refill_line_i,
	output logic fetch_valid_o,
	output logic fetch_except_o,
	output ifu_pkg::word_t fetch_data_o,
	output logic itlb_ena_o,
	output ifu_pkg::word_t itlb_vaddr_o,
	output logic itlb_fill_valid_o,
	output logic itlb_fill_ok_o,
	output ifu_pkg::word_t itlb_fill_paddr_o,
	output logic icache_ena_o,
	output ifu_pkg::word_t icache_addr_o,
	output logic icache_fill_valid_o,
	output ifu_pkg::word_t icache_fill_addr_o,
	output ifu_pkg::line_t icache_fill_line_o,
	output logic mem_valid_o,
	output ifu_pkg::word_t mem_addr_o,
	output logic walk_start_o,
	output ifu_pkg::word_t walk_vaddr_o,
	output logic refill_start_o,
	output ifu_pkg::word_t refill_paddr_o,
	mem_req_if.arbiter walk_mem,
	mem_req_if.arbiter refill_mem
);
	import ifu_pkg::*;

	fetch_state_t state;
	// one icache lookup after a good walk
	logic relook;
	logic unc_req;
	word_t paddr_q;
	logic accept;
	logic in_uncached;
	logic in_unmapped;
	logic itlb_hit;
	logic icache_hit;

	// the cycle of a fetch_valid_o pulse never accepts
	assign accept = (state == idle) && fetch_ena_i && !fetch_valid_o;
	assign in_uncached = fetch_addr_i >= uncached_base;
	assign in_unmapped = !in_uncached && (fetch_addr_i >= unmapped_base);
	assign itlb_hit = itlb_valid_i && itlb_hit_i;
	assign icache_hit = icache_valid_i && icache_hit_i;

	always_comb begin
		itlb_ena_o = 1'b0;
		itlb_vaddr_o = fetch_addr_i;
		icache_ena_o = 1'b0;
		icache_addr_o = fetch_addr_i;
		if (accept && !in_uncached) begin
			if (in_unmapped) begin
				icache_ena_o = 1'b1;
			end else begin
				itlb_ena_o = 1'b1;
				icache_ena_o = itlb_hit;
				icache_addr_o = itlb_paddr_i;
			end
		end else if (state == walk && relook) begin
			icache_ena_o = 1'b1;
			icache_addr_o = paddr_q;
		end
	end

	// memory port follows the active state
	always_comb begin
		mem_valid_o = 1'b0;
		mem_addr_o = paddr_q;
		case (state)
			walk: begin
				mem_valid_o = walk_mem.req_valid;
				mem_addr_o = walk_mem.req_addr;
			end
			refill: begin
				mem_valid_o = refill_mem.req_valid;
				mem_addr_o = refill_mem.req_addr;
			end
			uncached: begin
				mem_valid_o = unc_req;
			end
			default: begin
			end
		endcase
	end

	assign walk_mem.rsp_valid = mem_valid_i && (state == walk);
	assign walk_mem.rsp_data = mem_data_i;
	assign refill_mem.rsp_valid = mem_valid_i && (state == refill);
	assign refill_mem.rsp_data = mem_data_i;

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= idle;
			relook <= 1'b0;
			unc_req <= 1'b0;
			fetch_valid_o <= 1'b0;
			fetch_except_o <= 1'b0;
			itlb_fill_valid_o <= 1'b0;
			icache_fill_valid_o <= 1'b0;
			walk_start_o <= 1'b0;
			refill_start_o <= 1'b0;
		end else begin
			fetch_valid_o <= 1'b0;
			fetch_except_o <= 1'b0;
			itlb_fill_valid_o <= 1'b0;
			icache_fill_valid_o <= 1'b0;
			walk_start_o <= 1'b0;
			refill_start_o <= 1'b0;
			case (state)
				idle: begin
					if (accept) begin
						if (in_uncached) begin
							paddr_q <= fetch_addr_i;
							unc_req <= 1'b1;
							state <= uncached;
						end else if (!in_unmapped && !itlb_hit) begin
							walk_start_o <= 1'b1;
							walk_vaddr_o <= fetch_addr_i;
							state <= walk;
						end else if (icache_hit) begin
							fetch_valid_o <= 1'b1;
							fetch_data_o <= icache_data_i;
						end else begin
							paddr_q <= icache_addr_o;
							refill_start_o <= 1'b1;
							refill_paddr_o <= icache_addr_o;
							state <= refill;
						end
					end
				end
				walk: begin
					if (relook) begin
						relook <= 1'b0;
						if (icache_hit) begin
							fetch_valid_o <= 1'b1;
							fetch_data_o <= icache_data_i;
							state <= idle;
						end else begin
							refill_start_o <= 1'b1;
							refill_paddr_o <= paddr_q;
							state <= refill;
						end
					end else if (walk_done_i) begin
						itlb_fill_valid_o <= 1'b1;
						itlb_fill_ok_o <= !walk_fault_i;
						itlb_fill_paddr_o <= walk_paddr_i;
						if (walk_fault_i) begin
							fetch_valid_o <= 1'b1;
							fetch_except_o <= 1'b1;
							fetch_data_o <= '0;
							state <= idle;
						end else begin
							paddr_q <= walk_paddr_i;
							relook <= 1'b1;
						end
					end
				end
				refill: begin
					if (refill_done_i) begin
						icache_fill_valid_o <= 1'b1;
						icache_fill_addr_o <= line_base(paddr_q);
						icache_fill_line_o <= refill_line_i;
						fetch_valid_o <= 1'b1;
						fetch_data_o <= refill_line_i[$bits(word_t)*paddr_q[3:2] +: $bits(word_t)];
						state <= idle;
					end
				end
				uncached: begin
					if (mem_valid_i) begin
						unc_req <= 1'b0;
						fetch_valid_o <= 1'b1;
						fetch_data_o <= mem_data_i;
						state <= idle;
					end
				end
			endcase
		end
	end

endmodule

// ==== hdl/line_refill.sv ====
`timescale 1ns/10ps

module line_refill (
	input logic clk,
	input logic rst,
	input logic start_i,
	input ifu_pkg::word_t paddr_i,
	output logic done_o,
	output ifu_pkg::line_t line_o,
	mem_req_if.requester mem
);
	import ifu_pkg::*;

	logic busy;
	logic [1:0] cnt;
	word_t base_q;
	line_t line_q;

	// burst walks the line one word at a time
	assign mem.req_valid = busy;
	assign mem.req_addr = base_q + word_t'(cnt) * word_t'(word_bytes);

	assign line_o = line_q;

	always_ff @(posedge clk) begin
		if (!rst) begin
			busy <= 1'b0;
			cnt <= 2'd0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (start_i && !busy) begin
				busy <= 1'b1;
				cnt <= 2'd0;
			end else if (busy && mem.rsp_valid) begin
				if (cnt == 2'(words_per_line - 1)) begin
					busy <= 1'b0;
					done_o <= 1'b1;
				end
				// wraps back to zero after the last word
				cnt <= cnt + 2'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start_i && !busy) begin
			base_q <= line_base(paddr_i);
		end
		if (busy && mem.rsp_valid) begin
			line_q[$bits(word_t)*cnt +: $bits(word_t)] <= mem.rsp_data;
		end
	end

endmodule

// ==== hdl/page_walker.sv ====
`timescale 1ns/10ps

module page_walker (
	input logic clk,
	input logic rst,
	input logic start_i,
	input ifu_pkg::word_t vaddr_i,
	input ifu_pkg::word_t cat_base_i,
	output logic done_o,
	output logic fault_o,
	output ifu_pkg::word_t paddr_o,
	mem_req_if.requester mem
);
	import ifu_pkg::*;

	logic busy;
	logic level;
	word_t vaddr_q;
	word_t pte1_q;
	logic pte_ok;

	// level 0 indexed by vaddr[31:22], level 1 by vaddr[21:12]
	assign mem.req_valid = busy;
	assign mem.req_addr = level ? {pte_frame(pte1_q), vaddr_q[21:12], 2'b00}
		: {cat_base_i[31:12], vaddr_q[31:22], 2'b00};

	assign pte_ok = mem.rsp_data[pte_valid_bit];

	always_ff @(posedge clk) begin
		if (!rst) begin
			busy <= 1'b0;
			level <= 1'b0;
			done_o <= 1'b0;
			fault_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (start_i && !busy) begin
				busy <= 1'b1;
				level <= 1'b0;
			end else if (busy && mem.rsp_valid) begin
				if (!pte_ok || level) begin
					// this entry decides the walk
					busy <= 1'b0;
					done_o <= 1'b1;
					fault_o <= !pte_ok;
				end else begin
					level <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start_i && !busy) begin
			vaddr_q <= vaddr_i;
		end
		if (busy && mem.rsp_valid) begin
			if (!level) begin
				pte1_q <= mem.rsp_data;
			end else begin
				paddr_o <= {pte_frame(mem.rsp_data), vaddr_q[11:0]};
			end
		end
	end

endmodule

// ==== hdl/mem_req_if.sv ====
`timescale 1ns/10ps

interface mem_req_if;
	import ifu_pkg::*;

	logic req_valid;
	word_t req_addr;
	logic rsp_valid;
	word_t rsp_data;

	// address held until the one-cycle response
	modport requester (
		output req_valid,
		output req_addr,
		input rsp_valid,
		input rsp_data
	);

	modport arbiter (
		input req_valid,
		input req_addr,
		output rsp_valid,
		output rsp_data
	);

endinterface

// ==== hdl/ifu_pkg.sv ====
package ifu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [127:0] line_t;
	typedef logic [19:0] frame_t;

	localparam int unsigned words_per_line = 4;
	localparam int unsigned word_bytes = 4;

	// region thresholds on the fetch address
	localparam word_t uncached_base = 32'h0000_0010;
	localparam word_t unmapped_base = 32'h0000_0005;

	// valid flag on top of a table entry with the frame just below it
	localparam int unsigned pte_valid_bit = 31;

	typedef enum logic [1:0] {
		idle,
		walk,
		refill,
		uncached
	} fetch_state_t;

	function automatic frame_t pte_frame(word_t pte);
		return pte[pte_valid_bit-1 -: $bits(frame_t)];
	endfunction

	// first byte of the cache line holding addr
	function automatic word_t line_base(word_t addr);
		return addr & ~word_t'(words_per_line * word_bytes - 1);
	endfunction

endpackage
